// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_thermo_ctrl
FILELIST = filelist.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
hw/thermo_pkg.sv
hw/temp_filter.sv
hw/band_compare.sv
hw/mode_fsm.sv
hw/thermo_ctrl_top.sv
tb/mode_fsm_assert.sv
tb/tb_thermo_ctrl.sv

// File: hw/band_compare.sv
// Hysteresis band around the setpoint with registered above and below flags
`timescale 1ns/10ps

module band_compare
    import thermo_pkg::*;
#(
    parameter int unsigned HYSTERESIS = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t avg,
    input  temp_t   target_temp,
    output zone_t   zone
);

    logic [31:0] upper_sum;
    temp_t       upper;
    temp_t       lower;
    logic        valid_q;
    logic        below_q;
    logic        above_q;

    // Upper limit clamps at full scale
    assign upper_sum = 32'(target_temp) + HYSTERESIS;
    assign upper     = (upper_sum > 32'd255) ? 8'hFF : temp_t'(upper_sum);

    // Lower limit clamps at zero
    assign lower = (32'(target_temp) < HYSTERESIS) ? 8'h00
                 : temp_t'(32'(target_temp) - HYSTERESIS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= avg.valid;
        end
    end

    // Strict compares, so a saturated limit can never trip
    always_ff @(posedge clk) begin
        if (avg.valid) begin
            below_q <= avg.temp < lower;
            above_q <= avg.temp > upper;
        end
    end

    assign zone = '{valid: valid_q, below_lower: below_q, above_upper: above_q};

endmodule

// File: hw/mode_fsm.sv
// Heat, cool and fan mode state machine with registered actuator decode
`timescale 1ns/10ps

module mode_fsm
    import thermo_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  zone_t     zone,
    output actuator_t act
);

    mode_e     state_q;
    mode_e     state_next;
    actuator_t act_q;

    // Actuator pattern per mode
    function automatic actuator_t decode(input mode_e mode);
        actuator_t a;
        a = '0;
        case (mode)
            HEATING: begin
                a.heat = 1'b1;
                a.fan  = 1'b1;
            end
            COOLING: begin
                a.cool = 1'b1;
                a.fan  = 1'b1;
            end
            FAN_ONLY: begin
                a.fan = 1'b1;
            end
            default: begin
                a = '0;
            end
        endcase
        return a;
    endfunction

    always_comb begin
        state_next = state_q;
        case (state_q)
            IDLE: begin
                if (zone.below_lower) begin
                    state_next = HEATING;
                end else if (zone.above_upper) begin
                    state_next = COOLING;
                end
            end
            HEATING: begin
                if (!zone.below_lower) begin
                    state_next = FAN_ONLY;
                end
            end
            COOLING: begin
                if (!zone.above_upper) begin
                    state_next = FAN_ONLY;
                end
            end
            FAN_ONLY: begin
                // Run-on ends after one in-band sample
                if (zone.below_lower) begin
                    state_next = HEATING;
                end else if (zone.above_upper) begin
                    state_next = COOLING;
                end else begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    // State steps only on a band result, outputs trail by a cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            act_q   <= '0;
        end else begin
            if (zone.valid) begin
                state_q <= state_next;
            end
            act_q <= decode(state_q);
        end
    end

    assign act = act_q;

endmodule

// File: hw/temp_filter.sv
// Moving average filter over the most recent accepted temperature readings
`timescale 1ns/10ps

module temp_filter
    import thermo_pkg::*;
#(
    parameter int unsigned AVG_LOG2 = 2
) (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t sample_in,
    output sample_t avg
);

    localparam int unsigned WIN   = 1 << AVG_LOG2;
    localparam int unsigned SUM_W = $bits(temp_t) + AVG_LOG2;

    // Window slot 0 holds the newest reading
    temp_t            window [WIN];
    logic [SUM_W-1:0] sum_q;
    logic [SUM_W-1:0] sum_next;
    logic [SUM_W-1:0] sum_scaled;
    logic             valid_q;
    temp_t            avg_q;

    // Newest reading in, oldest one out
    assign sum_next = sum_q
                    + SUM_W'(sample_in.temp)
                    - SUM_W'(window[WIN-1]);

    // Divide by window length
    assign sum_scaled = sum_next >> AVG_LOG2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < WIN; i++) begin
                window[i] <= '0;
            end
            sum_q <= '0;
        end else if (sample_in.valid) begin
            window[0] <= sample_in.temp;
            for (int i = 1; i < WIN; i++) begin
                window[i] <= window[i-1];
            end
            sum_q <= sum_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= sample_in.valid;
        end
    end

    // Average only loads on a strobe
    always_ff @(posedge clk) begin
        if (sample_in.valid) begin
            avg_q <= temp_t'(sum_scaled);
        end
    end

    assign avg = '{valid: valid_q, temp: avg_q};

endmodule

// File: hw/thermo_ctrl_top.sv
// Thermostat control top level chaining the filter, band and mode stages
`timescale 1ns/10ps

module thermo_ctrl_top
    import thermo_pkg::*;
#(
    parameter int unsigned AVG_LOG2   = 2,
    parameter int unsigned HYSTERESIS = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  sample_t   sample_in,
    input  temp_t     target_temp,
    output actuator_t act
);

    sample_t avg;
    zone_t   zone;

    // Window average of incoming readings
    temp_filter #(
        .AVG_LOG2 (AVG_LOG2)
    ) u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .sample_in (sample_in),
        .avg       (avg)
    );

    // Setpoint band with hysteresis
    band_compare #(
        .HYSTERESIS (HYSTERESIS)
    ) u_band (
        .clk         (clk),
        .rst_n       (rst_n),
        .avg         (avg),
        .target_temp (target_temp),
        .zone        (zone)
    );

    // Mode state and actuator drive
    mode_fsm u_mode (
        .clk   (clk),
        .rst_n (rst_n),
        .zone  (zone),
        .act   (act)
    );

endmodule

// File: hw/thermo_pkg.sv
// Shared temperature, sample, zone, mode and actuator types for the thermostat pipeline
package thermo_pkg;

    // Raw sensor units, no conversion applied
    typedef logic [7:0] temp_t;

    // Strobed reading, used both for sensor input and filter output
    typedef struct packed {
        logic  valid;
        temp_t temp;
    } sample_t;

    // Band result for one filtered sample
    typedef struct packed {
        logic valid;
        logic below_lower;
        logic above_upper;
    } zone_t;

    // Climate modes
    typedef enum logic [1:0] {
        IDLE     = 2'b00,
        HEATING  = 2'b01,
        COOLING  = 2'b10,
        FAN_ONLY = 2'b11
    } mode_e;

    // Equipment drive bits
    typedef struct packed {
        logic heat;
        logic cool;
        logic fan;
    } actuator_t;

endpackage

// File: tb/mode_fsm_assert.sv
// Concurrent assertions on the mode state machine and the bind that attaches them
`timescale 1ns/10ps

module mode_fsm_assert
    import thermo_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input zone_t     zone,
    input mode_e     state_q,
    input actuator_t act
);

    heat_cool_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(act.heat && act.cool)
    ) else $error("heat and cool are on together");

    // Fan runs whenever a compressor mode is active
    fan_with_drive: assert property (
        @(posedge clk) disable iff (!rst_n) (act.heat || act.cool) |-> act.fan
    ) else $error("heat or cool on without fan");

    state_moves_on_zone: assert property (
        @(posedge clk) disable iff (!rst_n) (state_q != $past(state_q)) |-> $past(zone.valid)
    ) else $error("mode state changed without a band result");

endmodule

bind mode_fsm mode_fsm_assert u_mode_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .zone    (zone),
    .state_q (state_q),
    .act     (act)
);

// File: tb/tb_thermo_ctrl.sv
// Vector-driven testbench for the thermostat pipeline with per-test summary and timeout
`timescale 1ns/10ps

module tb_thermo_ctrl
    import thermo_pkg::*;
;

    localparam int RESET_CYCLES = 8;
    localparam int MAX_VECS     = 256;

    logic      clk;
    logic      rst_n;
    sample_t   sample_in;
    temp_t     target_temp;
    actuator_t act;

    int        vec_test   [MAX_VECS];
    logic      vec_valid  [MAX_VECS];
    temp_t     vec_temp   [MAX_VECS];
    temp_t     vec_target [MAX_VECS];
    actuator_t vec_act    [MAX_VECS];

    int num_vecs     = 0;
    int cycle_count  = 0;
    int cycle_limit  = 0;
    int errors       = 0;
    int test_errors  = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    thermo_ctrl_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample_in   (sample_in),
        .target_temp (target_temp),
        .act         (act)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Stops a run that never reaches the end of the vectors
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Run stopped at cycle %0d before all vectors were applied", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // Vector columns are test, valid, reading, target, heat, cool, fan
    task automatic load_vectors();
        int               fd;
        int               got;
        int               fields [7];
        logic [8*120-1:0] line;
        fd = $fopen("tb/thermo_vectors.txt", "r");
        if (fd == 0) begin
            $display("Vector file tb/thermo_vectors.txt could not be opened");
            return;
        end
        while (!$feof(fd) && num_vecs < MAX_VECS) begin
            line = '0;
            got = $fgets(line, fd);
            if (got > 0 &&
                $sscanf(line, "%d %d %d %d %d %d %d", fields[0], fields[1], fields[2],
                        fields[3], fields[4], fields[5], fields[6]) == 7) begin
                vec_test[num_vecs]   = fields[0];
                vec_valid[num_vecs]  = fields[1][0];
                vec_temp[num_vecs]   = temp_t'(fields[2]);
                vec_target[num_vecs] = temp_t'(fields[3]);
                vec_act[num_vecs]    = '{heat: fields[4][0], cool: fields[5][0],
                                         fan: fields[6][0]};
                num_vecs++;
            end
        end
        $fclose(fd);
    endtask

    task automatic check_act(input int idx);
        if (act !== vec_act[idx]) begin
            $display("ERR %0t act expected %b got %b at vector %0d",
                     $time, vec_act[idx], act, idx);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test(input int test_id);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %0d done, no mismatches", test_id);
        end else begin
            tests_failed++;
            $display("Test %0d done, %0d mismatches", test_id, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        int cur_test;
        rst_n       <= 1'b0;
        sample_in   <= '0;
        target_temp <= '0;
        load_vectors();
        cycle_limit = num_vecs + RESET_CYCLES + 20;
        if (num_vecs == 0) begin
            $display("No vectors were loaded, so nothing was tested");
            errors++;
        end

        // Outputs must stay clear while reset is held
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (act !== '0) begin
                $display("ERR %0t act expected 000 got %b during reset", $time, act);
                errors++;
                test_errors++;
            end
        end
        @(posedge clk);
        rst_n <= 1'b1;

        cur_test = (num_vecs > 0) ? vec_test[0] : 0;
        for (int i = 0; i < num_vecs; i++) begin
            if (vec_test[i] != cur_test) begin
                report_test(cur_test);
                cur_test = vec_test[i];
            end
            @(posedge clk);
            sample_in   <= '{valid: vec_valid[i], temp: vec_temp[i]};
            target_temp <= vec_target[i];
            @(negedge clk);
            check_act(i);
        end
        if (num_vecs > 0) begin
            report_test(cur_test);
        end

        $display("Totals: %0d tests, %0d failed, %0d mismatches", tests_run, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb/thermo_vectors.txt
# Columns: test valid reading target heat cool fan, one line per clock cycle
# Expected actuator bits already include the four-cycle pipeline latency
# test 1: in-band readings from reset
1 1 2 2 0 0 0
1 1 2 2 0 0 0
1 1 2 2 0 0 0
1 1 2 2 0 0 0
1 1 3 2 0 0 0
1 1 1 2 0 0 0
1 0 0 2 0 0 0
1 0 0 2 0 0 0
# test 2: heating, fan run-on, back to idle
2 1 20 20 0 0 0
2 1 20 20 0 0 0
2 1 20 20 0 0 0
2 1 20 20 0 0 0
2 0 0 20 1 0 1
2 0 0 20 1 0 1
2 0 0 20 1 0 1
2 0 0 20 0 0 1
2 1 20 20 0 0 1
2 0 0 20 0 0 1
2 0 0 20 0 0 1
2 0 0 20 0 0 1
# test 3: cooling, fan run-on, back to idle
3 1 30 20 0 0 0
3 1 30 20 0 0 0
3 1 30 20 0 0 0
3 1 20 20 0 0 0
3 1 20 20 0 0 0
3 1 20 20 0 1 1
3 0 0 20 0 1 1
3 0 0 20 0 1 1
3 0 0 20 0 1 1
3 1 20 20 0 0 1
3 0 0 20 0 0 1
3 0 0 20 0 0 1
3 0 0 20 0 0 1
# test 4: single high and low spikes stay in band
4 1 31 20 0 0 0
4 1 20 20 0 0 0
4 1 12 20 0 0 0
4 1 20 20 0 0 0
4 1 20 20 0 0 0
4 1 20 20 0 0 0
4 1 20 20 0 0 0
# test 5: heating, fan only, then straight to cooling
5 1 4 20 0 0 0
5 1 20 20 0 0 0
5 1 36 20 0 0 0
5 1 36 20 0 0 0
5 0 0 20 1 0 1
5 0 0 20 1 0 1
5 0 0 20 0 0 1
5 0 0 20 0 1 1
# test 6: gaps with target changes, then saturated limits at 0 and 255
6 0 99 200 0 1 1
6 0 99 0 0 1 1
6 0 99 255 0 1 1
6 0 99 20 0 1 1
6 1 0 0 0 1 1
6 1 0 0 0 1 1
6 1 0 0 0 1 1
6 1 0 0 0 1 1
6 1 0 0 0 1 1
6 1 0 0 0 1 1
6 1 255 0 0 1 1
6 1 255 63 0 0 1
6 1 255 127 0 0 0
6 1 255 191 0 0 0
6 1 255 255 0 0 0
6 0 0 255 0 0 0
6 0 0 255 0 0 0
6 0 0 255 0 0 0
6 0 0 255 0 0 0
